//--- hw/cam_pkg.sv
`default_nettype none

package cam_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------

  // Number of locations in the store.
  localparam int unsigned cam_depth = 110;

  // Index, word and key widths.
  localparam int unsigned idx_w = 7;
  localparam int unsigned data_w = 16;
  localparam int unsigned key_w = 8;

  // The recirculation FIFO occupancy runs from 0 up to cam_depth.
  localparam int unsigned cnt_w = $clog2(cam_depth + 1);

  // ------------------------------
  // Types
  // ------------------------------

  typedef logic [idx_w-1:0] cam_idx_t;
  typedef logic [data_w-1:0] cam_data_t;

  // The key is the low key_w bits of a stored word.
  typedef logic [key_w-1:0] cam_key_t;

  // Highest location number, used for counter and pointer wrap.
  localparam cam_idx_t last_idx = cam_idx_t'(cam_depth - 1);

  // Write command broadcast to every location.
  typedef struct packed {
    logic      en;
    cam_idx_t  idx;
    cam_data_t data;
  } cam_wr_t;

  // Invalidate one location and hand its index back to the allocator.
  typedef struct packed {
    logic     en;
    cam_idx_t idx;
  } cam_free_t;

  // Registered snoop result.
  typedef struct packed {
    logic      hit;
    cam_idx_t  idx;
    cam_data_t data;
  } cam_hit_t;

  // Allocator state. Fresh locations are handed out first, freed ones after.
  typedef enum logic {
    ALLOC_FRESH   = 1'b0,
    ALLOC_RECYCLE = 1'b1
  } alloc_mode_e;

endpackage

`default_nettype wire

//--- hw/cam_loc_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module cam_loc_alloc (
  input  logic               clk,
  input  logic               rst_an,
  input  logic               wvalid,
  input  cam_pkg::cam_data_t wdata,
  output logic               wready,
  input  cam_pkg::cam_free_t free,
  output cam_pkg::cam_wr_t   wr
);

  cam_pkg::alloc_mode_e mode;
  cam_pkg::cam_idx_t    fresh_idx;

  cam_pkg::cam_idx_t         fifo_mem [cam_pkg::cam_depth];
  cam_pkg::cam_idx_t         fifo_rd_ptr;
  cam_pkg::cam_idx_t         fifo_wr_ptr;
  logic [cam_pkg::cnt_w-1:0] fifo_cnt;
  logic                      fifo_empty;

  logic accept;
  logic pop;

  function automatic cam_pkg::cam_idx_t next_ptr(input cam_pkg::cam_idx_t ptr);
    if (ptr == cam_pkg::last_idx) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ------------------------------
  // Write acceptance
  // ------------------------------

  assign fifo_empty = (fifo_cnt == '0);

  // While fresh locations remain a write is always taken. Afterwards it
  // waits for a freed index.
  assign wready = (mode == cam_pkg::ALLOC_FRESH) || !fifo_empty;
  assign accept = wvalid && wready;
  assign pop    = accept && (mode == cam_pkg::ALLOC_RECYCLE);

  always_comb begin
    wr.en   = accept;
    wr.idx  = (mode == cam_pkg::ALLOC_FRESH) ? fresh_idx : fifo_mem[fifo_rd_ptr];
    wr.data = wdata;
  end

  // ------------------------------
  // Fresh location counter
  // ------------------------------

  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      mode      <= cam_pkg::ALLOC_FRESH;
      fresh_idx <= '0;
    end else if (accept && (mode == cam_pkg::ALLOC_FRESH)) begin
      // The last fresh location moves the allocator over to the FIFO for good.
      if (fresh_idx == cam_pkg::last_idx) begin
        mode <= cam_pkg::ALLOC_RECYCLE;
      end else begin
        fresh_idx <= fresh_idx + 1'b1;
      end
    end
  end

  // ------------------------------
  // Recirculation FIFO
  // ------------------------------

  // Freed indices may arrive in either mode. They are only popped once the
  // counter is exhausted. A location can be freed only after it was handed
  // out, so the FIFO never holds more than cam_depth entries.
  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      fifo_rd_ptr <= '0;
      fifo_wr_ptr <= '0;
      fifo_cnt    <= '0;
    end else begin
      if (free.en) begin
        fifo_wr_ptr <= next_ptr(fifo_wr_ptr);
      end
      if (pop) begin
        fifo_rd_ptr <= next_ptr(fifo_rd_ptr);
      end
      case ({free.en, pop})
        2'b10: fifo_cnt <= fifo_cnt + 1'b1;
        2'b01: fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  // A pushed index becomes visible to the read side one cycle later.
  always_ff @(posedge clk) begin
    if (free.en) begin
      fifo_mem[fifo_wr_ptr] <= free.idx;
    end
  end

endmodule

`default_nettype wire

//--- hw/cam_entry.sv
`timescale 1ns/1ps
`default_nettype none

module cam_entry #(
  parameter int unsigned entry_index = 0
) (
  input  logic               clk,
  input  logic               rst_an,
  input  cam_pkg::cam_wr_t   wr,
  input  cam_pkg::cam_free_t free,
  input  cam_pkg::cam_key_t  key,
  output logic               match,
  output cam_pkg::cam_data_t data
);

  localparam cam_pkg::cam_idx_t own_idx = cam_pkg::cam_idx_t'(entry_index);

  logic wr_sel;
  logic free_sel;
  logic valid;

  assign wr_sel   = wr.en && (wr.idx == own_idx);
  assign free_sel = free.en && (free.idx == own_idx);

  always_ff @(posedge clk) begin
    if (wr_sel) begin
      data <= wr.data;
    end
  end

  // A write only targets a free location and a free only a valid one, so
  // both never select this entry at the same edge.
  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      valid <= 1'b0;
    end else if (wr_sel) begin
      valid <= 1'b1;
    end else if (free_sel) begin
      valid <= 1'b0;
    end
  end

  assign match = valid && (data[cam_pkg::key_w-1:0] == key);

endmodule

`default_nettype wire

//--- hw/cam_match_merge.sv
`timescale 1ns/1ps
`default_nettype none

module cam_match_merge (
  input  logic                          clk,
  input  logic                          rst_an,
  input  logic                          svalid,
  input  logic [cam_pkg::cam_depth-1:0] match,
  input  cam_pkg::cam_data_t            entry_data [cam_pkg::cam_depth],
  output cam_pkg::cam_free_t            free,
  output cam_pkg::cam_hit_t             result
);

  logic               any_match;
  cam_pkg::cam_idx_t  sel_idx;
  cam_pkg::cam_data_t sel_data;

  logic               hit_q;
  cam_pkg::cam_idx_t  idx_q;
  cam_pkg::cam_data_t data_q;

  // ------------------------------
  // Priority select
  // ------------------------------

  // Scan from the top down so the lowest matching location is the last
  // one written and wins.
  always_comb begin
    sel_idx  = '0;
    sel_data = '0;
    for (int i = cam_pkg::cam_depth - 1; i >= 0; i--) begin
      if (match[i]) begin
        sel_idx  = cam_pkg::cam_idx_t'(i);
        sel_data = entry_data[i];
      end
    end
  end

  assign any_match = |match;

  // The winner is released at the same edge that registers the result.
  always_comb begin
    free.en  = svalid && any_match;
    free.idx = sel_idx;
  end

  // ------------------------------
  // Result register
  // ------------------------------

  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      hit_q <= 1'b0;
    end else begin
      hit_q <= free.en;
    end
  end

  always_ff @(posedge clk) begin
    if (free.en) begin
      idx_q  <= sel_idx;
      data_q <= sel_data;
    end
  end

  always_comb begin
    result.hit  = hit_q;
    result.idx  = idx_q;
    result.data = data_q;
  end

endmodule

`default_nettype wire

//--- hw/snoop_cam.sv
`timescale 1ns/1ps
`default_nettype none

module snoop_cam (
  input  logic               clk,
  input  logic               rst_an,
  input  logic               wvalid,
  input  cam_pkg::cam_data_t wdata,
  output logic               wready,
  input  logic               svalid,
  input  cam_pkg::cam_key_t  sin,
  output logic               hit,
  output cam_pkg::cam_data_t hit_data,
  output cam_pkg::cam_idx_t  hit_idx
);

  cam_pkg::cam_wr_t   wr;
  cam_pkg::cam_free_t free;
  cam_pkg::cam_hit_t  result;

  logic [cam_pkg::cam_depth-1:0] match;
  cam_pkg::cam_data_t            entry_data [cam_pkg::cam_depth];

  // ------------------------------
  // Location allocator
  // ------------------------------

  cam_loc_alloc alloc_inst (
    .clk    (clk),
    .rst_an (rst_an),
    .wvalid (wvalid),
    .wdata  (wdata),
    .wready (wready),
    .free   (free),
    .wr     (wr)
  );

  // ------------------------------
  // Storage locations
  // ------------------------------

  for (genvar g = 0; g < cam_pkg::cam_depth; g++) begin : g_entry
    cam_entry #(
      .entry_index (g)
    ) entry_inst (
      .clk    (clk),
      .rst_an (rst_an),
      .wr     (wr),
      .free   (free),
      .key    (sin),
      .match  (match[g]),
      .data   (entry_data[g])
    );
  end

  // ------------------------------
  // Match merge and result
  // ------------------------------

  cam_match_merge merge_inst (
    .clk        (clk),
    .rst_an     (rst_an),
    .svalid     (svalid),
    .match      (match),
    .entry_data (entry_data),
    .free       (free),
    .result     (result)
  );

  assign hit      = result.hit;
  assign hit_idx  = result.idx;
  assign hit_data = result.data;

endmodule

`default_nettype wire

//--- tests/snoop_cam_sva.sv
`timescale 1ns/1ps
`default_nettype none

module snoop_cam_sva (
  input logic              clk,
  input logic              rst_an,
  input logic              svalid,
  input logic              wready,
  input logic              hit,
  input cam_pkg::cam_idx_t hit_idx
);

  int unsigned fail_cnt = 0;
  logic [1:0]  run_cycles;

  // Counts the first edges after reset so that $past has history.
  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      run_cycles <= '0;
    end else if (run_cycles != 2'd2) begin
      run_cycles <= run_cycles + 1'b1;
    end
  end

  hit_needs_snoop: assert property (@(posedge clk) disable iff (!rst_an)
    ((run_cycles == 2'd2) && hit) |-> $past(svalid))
  else begin
    $error("hit is high without a snoop in the cycle before");
    fail_cnt++;
  end

  ready_after_reset: assert property (@(posedge clk) $rose(rst_an) |-> wready)
  else begin
    $error("wready is low in the first cycle after reset");
    fail_cnt++;
  end

  hit_idx_in_range: assert property (@(posedge clk) disable iff (!rst_an)
    hit |-> (hit_idx < cam_pkg::cam_depth))
  else begin
    $error("hit_idx 0x%0h is outside the store", hit_idx);
    fail_cnt++;
  end

endmodule

bind snoop_cam snoop_cam_sva sva_inst (
  .clk     (clk),
  .rst_an  (rst_an),
  .svalid  (svalid),
  .wready  (wready),
  .hit     (hit),
  .hit_idx (hit_idx)
);

`default_nettype wire

//--- tests/snoop_cam_tb.sv
`timescale 1ns/1ps
`default_nettype none

module snoop_cam_tb;

  localparam int clk_period   = 40;
  localparam int reset_cycles = 16;
  localparam int write_ops    = 116;
  localparam int snoop_ops    = 16;
  localparam int op_count     = reset_cycles + write_ops + snoop_ops;
  localparam int timeout_ns   = op_count * clk_period * 4;
  localparam int ready_wait   = 8;

  logic               clk;
  logic               rst_an;
  logic               wvalid;
  cam_pkg::cam_data_t wdata;
  logic               wready;
  logic               svalid;
  cam_pkg::cam_key_t  sin;
  logic               hit;
  cam_pkg::cam_data_t hit_data;
  cam_pkg::cam_idx_t  hit_idx;

  // Reference model of the store and its allocation order.
  cam_pkg::cam_data_t m_data [cam_pkg::cam_depth];
  logic               m_valid [cam_pkg::cam_depth];
  int                 free_q [$];
  int                 fresh_cnt;

  logic [31:0]       lcg_state;
  int                test_errors;
  int                pass_cnt;
  int                fail_cnt;
  int unsigned       sva_seen;
  int                picks [4];
  cam_pkg::cam_key_t old_keys [4];
  cam_pkg::cam_key_t new_keys [4];
  cam_pkg::cam_key_t dup_key;

  snoop_cam snoop_cam_inst (
    .clk      (clk),
    .rst_an   (rst_an),
    .wvalid   (wvalid),
    .wdata    (wdata),
    .wready   (wready),
    .svalid   (svalid),
    .sin      (sin),
    .hit      (hit),
    .hit_data (hit_data),
    .hit_idx  (hit_idx)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  // ------------------------------
  // Model and stimulus helpers
  // ------------------------------

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic int find_entry(input cam_pkg::cam_key_t key);
    for (int i = 0; i < cam_pkg::cam_depth; i++) begin
      if (m_valid[i] && (m_data[i][cam_pkg::key_w-1:0] == key)) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic logic key_in_use(input cam_pkg::cam_key_t key);
    return find_entry(key) >= 0;
  endfunction

  function automatic cam_pkg::cam_key_t unused_key();
    cam_pkg::cam_key_t k;
    k = cam_pkg::cam_key_t'(next_rand());
    while (key_in_use(k)) begin
      k = cam_pkg::cam_key_t'(next_rand());
    end
    return k;
  endfunction

  function automatic cam_pkg::cam_data_t make_word(input cam_pkg::cam_key_t key);
    logic [15:0] r;
    r = next_rand();
    return {r[15:8], key};
  endfunction

  // Fresh locations go out in order, then freed ones in the order they were freed.
  function automatic int take_index();
    int idx;
    if (fresh_cnt < cam_pkg::cam_depth) begin
      idx = fresh_cnt;
      fresh_cnt++;
    end else begin
      idx = free_q.pop_front();
    end
    return idx;
  endfunction

  function automatic logic writer_ready();
    return (fresh_cnt < cam_pkg::cam_depth) || (free_q.size() != 0);
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic write_word(input cam_pkg::cam_data_t w);
    int waited;
    int idx;
    waited = 0;
    @(posedge clk);
    wvalid <= 1'b1;
    wdata  <= w;
    @(negedge clk);
    while (!wready && (waited < ready_wait)) begin
      waited++;
      @(negedge clk);
    end
    if (wready) begin
      idx = take_index();
      m_data[idx]  = w;
      m_valid[idx] = 1'b1;
    end else begin
      $display("ERROR: write of 0x%0h was never accepted, wready stayed low", w);
      test_errors++;
    end
    @(posedge clk);
    wvalid <= 1'b0;
  endtask

  // The result shows one edge after the snoop edge and lasts one cycle.
  task automatic snoop_key(input cam_pkg::cam_key_t key);
    int idx;
    idx = find_entry(key);
    @(posedge clk);
    svalid <= 1'b1;
    sin    <= key;
    @(posedge clk);
    svalid <= 1'b0;
    @(negedge clk);
    expect_eq("hit", hit, idx >= 0);
    if (idx >= 0) begin
      expect_eq("hit_idx", hit_idx, idx);
      expect_eq("hit_data", hit_data, m_data[idx]);
      m_valid[idx] = 1'b0;
      free_q.push_back(idx);
    end
    @(negedge clk);
    expect_eq("hit", hit, 1'b0);
  endtask

  task automatic close_test(input string name);
    int unsigned sva_now;
    int          errs;
    sva_now  = snoop_cam_inst.sva_inst.fail_cnt;
    errs     = test_errors + int'(sva_now - sva_seen);
    sva_seen = sva_now;
    if (errs == 0) begin
      pass_cnt++;
      $display("[%s] pass", name);
    end else begin
      fail_cnt++;
      $display("[%s] fail with %0d errors", name, errs);
    end
    test_errors = 0;
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    rst_an      = 1'b0;
    wvalid      = 1'b0;
    wdata       = '0;
    svalid      = 1'b0;
    sin         = '0;
    lcg_state   = 32'd25980;
    fresh_cnt   = 0;
    test_errors = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    sva_seen    = 0;
    picks       = '{5, 0, 109, 42};
    for (int i = 0; i < cam_pkg::cam_depth; i++) begin
      m_valid[i] = 1'b0;
      m_data[i]  = '0;
    end

    repeat (reset_cycles) @(posedge clk);
    rst_an <= 1'b1;
    @(negedge clk);
    expect_eq("wready", wready, 1'b1);
    expect_eq("hit", hit, 1'b0);
    close_test("after_reset");

    for (int i = 0; i < cam_pkg::cam_depth; i++) begin
      write_word(make_word(unused_key()));
    end
    @(negedge clk);
    expect_eq("wready", wready, writer_ready());
    // A pending write must stay blocked while the misses free nothing.
    @(posedge clk);
    wvalid <= 1'b1;
    wdata  <= make_word(unused_key());
    repeat (3) snoop_key(unused_key());
    expect_eq("wready", wready, 1'b0);
    @(posedge clk);
    wvalid <= 1'b0;
    close_test("filling");

    for (int i = 0; i < 4; i++) begin
      old_keys[i] = m_data[picks[i]][cam_pkg::key_w-1:0];
      snoop_key(old_keys[i]);
    end
    snoop_key(unused_key());
    close_test("lookup");

    snoop_key(old_keys[0]);
    expect_eq("wready", wready, writer_ready());
    for (int i = 0; i < 4; i++) begin
      new_keys[i] = unused_key();
      write_word(make_word(new_keys[i]));
    end
    @(negedge clk);
    expect_eq("wready", wready, writer_ready());
    for (int i = 0; i < 4; i++) begin
      snoop_key(new_keys[i]);
    end
    close_test("free_recycle");

    // Two words share one key. The lower index must win first.
    dup_key = unused_key();
    write_word(make_word(dup_key));
    write_word(make_word(dup_key));
    repeat (3) snoop_key(dup_key);
    close_test("duplicate_keys");

    $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("ERROR: watchdog expired after %0d ns before the tests completed", timeout_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hw/cam_pkg.sv
hw/cam_loc_alloc.sv
hw/cam_entry.sv
hw/cam_match_merge.sv
hw/snoop_cam.sv
tests/snoop_cam_sva.sv
tests/snoop_cam_tb.sv

//--- Bender.yml
package:
  name: snoop_cam

sources:
  - files:
      - hw/cam_pkg.sv
      - hw/cam_loc_alloc.sv
      - hw/cam_entry.sv
      - hw/cam_match_merge.sv
      - hw/snoop_cam.sv
  - target: test
    files:
      - tests/snoop_cam_sva.sv
      - tests/snoop_cam_tb.sv
